//--- Makefile
TOOL       := verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := tb_networkadapter_ct
FILELIST   := networkadapter_ct.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- mp_endpoint.sv
`timescale 1ns/100ps

module mp_endpoint (
  input  logic      clk,
  input  logic      reset_i,
  wb_slave_if.slave bus,
  noc_link_if.rx    rx_in,
  noc_link_if.tx    tx_out,
  output logic      irq_o
);
  import na_pkg::*;

  logic              ack_q;
  logic [31:0]       dat_r_q;
  logic [mp_aw:0]    rx_count_q;
  logic              wb_access;
  logic              rx_push;
  logic              rx_pop;

  noc_link_if wr_link ();
  noc_link_if rd_link ();

  noc_buffer #(
    .depth (mp_fifo_depth)
  ) u_tx_fifo (
    .clk      (clk),
    .reset_i  (reset_i),
    .in_link  (wr_link),
    .out_link (tx_out)
  );

  noc_buffer #(
    .depth (mp_fifo_depth)
  ) u_rx_fifo (
    .clk      (clk),
    .reset_i  (reset_i),
    .in_link  (rx_in),
    .out_link (rd_link)
  );

  assign wb_access = bus.req && !ack_q;
  assign bus.ack = ack_q;
  assign bus.dat_r = dat_r_q;

  // Writes to a full transmit FIFO see no ready and are lost
  assign wr_link.flit = bus.dat_w;
  assign wr_link.last = (bus.adr == reg_mp_last);
  assign wr_link.valid = wb_access && bus.we &&
                         ((bus.adr == reg_mp_data) || (bus.adr == reg_mp_last));

  assign rd_link.ready = wb_access && !bus.we && (bus.adr == reg_mp_data);

  assign rx_push = rx_in.valid && rx_in.ready;
  assign rx_pop = rd_link.valid && rd_link.ready;
  assign irq_o = (rx_count_q != '0);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ack_q <= 1'b0;
      rx_count_q <= '0;
    end else begin
      ack_q <= wb_access;
      case ({rx_push, rx_pop})
        2'b10:   rx_count_q <= rx_count_q + 1'b1;
        2'b01:   rx_count_q <= rx_count_q - 1'b1;
        default: rx_count_q <= rx_count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wb_access) begin
      case (bus.adr)
        reg_mp_data:   dat_r_q <= rd_link.valid ? rd_link.flit : 32'b0;
        reg_mp_status: dat_r_q <= {{(31 - mp_aw){1'b0}}, rx_count_q};
        default:       dat_r_q <= 32'b0;
      endcase
    end
  end

endmodule

//--- na_conf.sv
`timescale 1ns/100ps

module na_conf #(
  parameter logic [4:0] TILE_ID = 5'd3
) (
  input  logic      clk,
  input  logic      reset_i,
  wb_slave_if.slave bus,
  noc_link_if.rx    query_in,
  noc_link_if.tx    reply_out
);
  import na_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_take_addr,
    st_send_hdr,
    st_send_data
  } state_e;

  state_e                state_q;
  logic [4:0]            src_q;
  logic [flit_width-1:0] data_q;
  logic [flit_width-1:0] hdr;
  logic [31:0]           scratch_q;
  logic [31:0]           dat_r_q;
  logic                  ack_q;
  logic                  wb_access;
  logic                  q_fire;
  logic                  r_fire;

  function automatic logic [31:0] reg_value(input logic [wb_adr_width-1:0] offset,
                                            input logic [31:0] scratch);
    case (offset)
      reg_tile_id: return {27'b0, TILE_ID};
      reg_scratch: return scratch;
      default:     return 32'b0;
    endcase
  endfunction

  assign wb_access = bus.req && !ack_q;
  assign bus.ack = ack_q;
  assign bus.dat_r = dat_r_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ack_q <= 1'b0;
      scratch_q <= '0;
    end else begin
      ack_q <= wb_access;
      if (wb_access && bus.we && (bus.adr == reg_scratch)) begin
        scratch_q <= bus.dat_w;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wb_access) begin
      dat_r_q <= reg_value(bus.adr, scratch_q);
    end
  end

  // Query responder
  assign q_fire = query_in.valid && query_in.ready;
  assign r_fire = reply_out.valid && reply_out.ready;
  assign query_in.ready = (state_q == st_idle) || (state_q == st_take_addr);

  always_comb begin
    hdr = '0;
    hdr[dest_msb:dest_lsb] = src_q;
    hdr[class_msb:class_lsb] = cls_reply;
    hdr[src_msb:src_lsb] = TILE_ID;
  end

  assign reply_out.valid = (state_q == st_send_hdr) || (state_q == st_send_data);
  assign reply_out.last = (state_q == st_send_data);
  assign reply_out.flit = (state_q == st_send_hdr) ? hdr : data_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle: begin
          // Header-only queries are dropped
          if (q_fire && !query_in.last) begin
            state_q <= st_take_addr;
          end
        end
        st_take_addr: begin
          if (q_fire && query_in.last) begin
            state_q <= st_send_hdr;
          end
        end
        st_send_hdr: begin
          if (r_fire) begin
            state_q <= st_send_data;
          end
        end
        default: begin
          if (r_fire) begin
            state_q <= st_idle;
          end
        end
      endcase
    end
  end

  // Register value is sampled together with the offset
  always_ff @(posedge clk) begin
    if (q_fire && (state_q == st_idle)) begin
      src_q <= query_in.flit[src_msb:src_lsb];
    end
    if (q_fire && (state_q == st_take_addr)) begin
      data_q <= reg_value(query_in.flit[wb_adr_width-1:0], scratch_q);
    end
  end

endmodule

//--- na_pkg.sv
package na_pkg;

  localparam int flit_width = 32;
  localparam int wb_adr_width = 20;

  // Header fields
  localparam int dest_msb = 31;
  localparam int dest_lsb = 27;
  localparam int class_msb = 26;
  localparam int class_lsb = 24;
  localparam int src_msb = 23;
  localparam int src_lsb = 19;

  typedef enum logic [2:0] {
    cls_msg   = 3'd0,
    cls_query = 3'd2,
    cls_reply = 3'd3
  } noc_class_e;

  // Wishbone ranges, address bits 23:20
  typedef enum logic [3:0] {
    sl_conf = 4'd0,
    sl_mp   = 4'd1
  } slave_e;

  // Configuration block
  localparam logic [wb_adr_width-1:0] reg_tile_id = 20'h0;
  localparam logic [wb_adr_width-1:0] reg_scratch = 20'h8;

  // Message-passing endpoint
  localparam logic [wb_adr_width-1:0] reg_mp_data = 20'h0;
  localparam logic [wb_adr_width-1:0] reg_mp_last = 20'h4;
  localparam logic [wb_adr_width-1:0] reg_mp_status = 20'h4;

  localparam int mp_fifo_depth = 8;
  localparam int mp_aw = $clog2(mp_fifo_depth);
  localparam int buf_depth = 4;

endpackage

//--- networkadapter_ct.f
na_pkg.sv
noc_link_if.sv
wb_slave_if.sv
noc_buffer.sv
noc_mux.sv
noc_demux.sv
wb_decode.sv
na_conf.sv
mp_endpoint.sv
networkadapter_ct.sv
networkadapter_ct_sva.sv
tb_networkadapter_ct.sv

//--- networkadapter_ct.sv
`timescale 1ns/100ps

module networkadapter_ct #(
  parameter logic [4:0] TILE_ID = 5'd3
) (
  input  logic                          clk,
  input  logic                          reset_i,
  input  logic [na_pkg::flit_width-1:0] noc_in_flit_i,
  input  logic                          noc_in_last_i,
  input  logic                          noc_in_valid_i,
  output logic                          noc_in_ready_o,
  output logic [na_pkg::flit_width-1:0] noc_out_flit_o,
  output logic                          noc_out_last_o,
  output logic                          noc_out_valid_o,
  input  logic                          noc_out_ready_i,
  input  logic [31:0]                   wbs_adr_i,
  input  logic [31:0]                   wbs_dat_i,
  input  logic                          wbs_cyc_i,
  input  logic                          wbs_stb_i,
  input  logic                          wbs_we_i,
  output logic [31:0]                   wbs_dat_o,
  output logic                          wbs_ack_o,
  output logic                          wbs_err_o,
  output logic                          irq_o
);

  noc_link_if in_ext ();
  noc_link_if in_buf ();
  noc_link_if conf_in ();
  noc_link_if mp_in ();
  noc_link_if conf_out ();
  noc_link_if mp_out ();
  noc_link_if mux_out ();
  noc_link_if out_ext ();
  wb_slave_if conf_bus ();
  wb_slave_if mp_bus ();

  assign in_ext.flit = noc_in_flit_i;
  assign in_ext.last = noc_in_last_i;
  assign in_ext.valid = noc_in_valid_i;
  assign noc_in_ready_o = in_ext.ready;

  assign noc_out_flit_o = out_ext.flit;
  assign noc_out_last_o = out_ext.last;
  assign noc_out_valid_o = out_ext.valid;
  assign out_ext.ready = noc_out_ready_i;

  noc_buffer u_inbuffer (
    .clk      (clk),
    .reset_i  (reset_i),
    .in_link  (in_ext),
    .out_link (in_buf)
  );

  noc_demux u_demux (
    .clk     (clk),
    .reset_i (reset_i),
    .in_link (in_buf),
    .to_conf (conf_in),
    .to_mp   (mp_in)
  );

  wb_decode u_slavedecode (
    .clk       (clk),
    .reset_i   (reset_i),
    .wbs_adr_i (wbs_adr_i),
    .wbs_dat_i (wbs_dat_i),
    .wbs_cyc_i (wbs_cyc_i),
    .wbs_stb_i (wbs_stb_i),
    .wbs_we_i  (wbs_we_i),
    .wbs_dat_o (wbs_dat_o),
    .wbs_ack_o (wbs_ack_o),
    .wbs_err_o (wbs_err_o),
    .conf_bus  (conf_bus),
    .mp_bus    (mp_bus)
  );

  na_conf #(
    .TILE_ID (TILE_ID)
  ) u_conf (
    .clk       (clk),
    .reset_i   (reset_i),
    .bus       (conf_bus),
    .query_in  (conf_in),
    .reply_out (conf_out)
  );

  mp_endpoint u_mp (
    .clk     (clk),
    .reset_i (reset_i),
    .bus     (mp_bus),
    .rx_in   (mp_in),
    .tx_out  (mp_out),
    .irq_o   (irq_o)
  );

  noc_mux u_mux (
    .clk      (clk),
    .reset_i  (reset_i),
    .in_a     (mp_out),
    .in_b     (conf_out),
    .out_link (mux_out)
  );

  noc_buffer u_outbuffer (
    .clk      (clk),
    .reset_i  (reset_i),
    .in_link  (mux_out),
    .out_link (out_ext)
  );

endmodule

//--- networkadapter_ct_sva.sv
`timescale 1ns/100ps

module networkadapter_ct_sva (
  input logic        clk,
  input logic        reset_i,
  input logic [31:0] out_flit_i,
  input logic        out_last_i,
  input logic        out_valid_i,
  input logic        out_ready_i,
  input logic        ack_i,
  input logic        err_i,
  input logic        irq_i
);

  // Stalled flit stays on the link
  a_out_stable: assert property (@(posedge clk) disable iff (reset_i)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_flit_i) && $stable(out_last_i))
    else $error("outgoing flit changed while stalled");

  a_ack_pulse: assert property (@(posedge clk) disable iff (reset_i) ack_i |=> !ack_i)
    else $error("ack held longer than one cycle");

  a_err_pulse: assert property (@(posedge clk) disable iff (reset_i) err_i |=> !err_i)
    else $error("err held longer than one cycle");

  a_ack_err: assert property (@(posedge clk) disable iff (reset_i) !(ack_i && err_i))
    else $error("ack and err together");

  a_reset: assert property (@(posedge clk)
    reset_i |=> !out_valid_i && !ack_i && !err_i && !irq_i)
    else $error("outputs active after reset");

endmodule

bind networkadapter_ct networkadapter_ct_sva sva0 (
  .clk         (clk),
  .reset_i     (reset_i),
  .out_flit_i  (noc_out_flit_o),
  .out_last_i  (noc_out_last_o),
  .out_valid_i (noc_out_valid_o),
  .out_ready_i (noc_out_ready_i),
  .ack_i       (wbs_ack_o),
  .err_i       (wbs_err_o),
  .irq_i       (irq_o)
);

//--- noc_buffer.sv
`timescale 1ns/100ps

module noc_buffer #(
  parameter int depth = na_pkg::buf_depth
) (
  input  logic       clk,
  input  logic       reset_i,
  noc_link_if.rx     in_link,
  noc_link_if.tx     out_link
);
  import na_pkg::*;

  // Entry is {last, flit}
  logic [flit_width:0]       mem [depth];
  logic [$clog2(depth)-1:0]  wr_ptr;
  logic [$clog2(depth)-1:0]  rd_ptr;
  logic [$clog2(depth):0]    count;
  logic                      push;
  logic                      pop;

  assign push = in_link.valid && in_link.ready;
  assign pop = out_link.valid && out_link.ready;

  assign in_link.ready = (int'(count) != depth);
  assign out_link.valid = (count != '0);
  assign out_link.flit = mem[rd_ptr][flit_width-1:0];
  assign out_link.last = mem[rd_ptr][flit_width];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= {in_link.last, in_link.flit};
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- noc_demux.sv
`timescale 1ns/100ps

module noc_demux (
  input  logic   clk,
  input  logic   reset_i,
  noc_link_if.rx in_link,
  noc_link_if.tx to_conf,
  noc_link_if.tx to_mp
);
  import na_pkg::*;

  logic locked_q;
  logic conf_q;
  logic is_query;
  logic conf_sel;

  assign is_query = (in_link.flit[class_msb:class_lsb] == cls_query);
  assign conf_sel = locked_q ? conf_q : is_query;

  assign to_conf.flit = in_link.flit;
  assign to_conf.last = in_link.last;
  assign to_conf.valid = in_link.valid && conf_sel;
  assign to_mp.flit = in_link.flit;
  assign to_mp.last = in_link.last;
  assign to_mp.valid = in_link.valid && !conf_sel;
  assign in_link.ready = conf_sel ? to_conf.ready : to_mp.ready;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      locked_q <= 1'b0;
      conf_q <= 1'b0;
    end else if (in_link.valid && in_link.ready) begin
      locked_q <= !in_link.last;
      conf_q <= conf_sel;
    end
  end

endmodule

//--- noc_link_if.sv
`timescale 1ns/100ps

interface noc_link_if;
  import na_pkg::*;

  logic [flit_width-1:0] flit;
  logic                  last;
  logic                  valid;
  logic                  ready;

  modport tx (
    output flit,
    output last,
    output valid,
    input  ready
  );

  modport rx (
    input  flit,
    input  last,
    input  valid,
    output ready
  );

endinterface

//--- noc_mux.sv
`timescale 1ns/100ps

module noc_mux (
  input  logic   clk,
  input  logic   reset_i,
  noc_link_if.rx in_a,
  noc_link_if.rx in_b,
  noc_link_if.tx out_link
);

  // Grant index 0 is in_a, 1 is in_b
  logic locked_q;
  logic sel_q;
  logic prio_q;
  logic sel;

  always_comb begin
    if (locked_q) begin
      sel = sel_q;
    end else if (in_a.valid && in_b.valid) begin
      sel = prio_q;
    end else begin
      sel = in_b.valid;
    end
  end

  assign out_link.valid = sel ? in_b.valid : in_a.valid;
  assign out_link.flit = sel ? in_b.flit : in_a.flit;
  assign out_link.last = sel ? in_b.last : in_a.last;
  assign in_a.ready = !sel && out_link.ready;
  assign in_b.ready = sel && out_link.ready;

  // Lock as soon as a flit is shown so the output stays stable under stall
  always_ff @(posedge clk) begin
    if (reset_i) begin
      locked_q <= 1'b0;
      sel_q <= 1'b0;
      prio_q <= 1'b0;
    end else if (out_link.valid) begin
      if (out_link.ready && out_link.last) begin
        locked_q <= 1'b0;
        prio_q <= !sel;
      end else begin
        locked_q <= 1'b1;
        sel_q <= sel;
      end
    end
  end

endmodule

//--- tb_networkadapter_ct.sv
`timescale 1ns/100ps

module tb_networkadapter_ct;

  localparam int timeout_cycles = 3000;

  logic        clk = 1'b0;
  logic        reset_i;
  logic [31:0] noc_in_flit_i;
  logic        noc_in_last_i;
  logic        noc_in_valid_i;
  logic        noc_in_ready_o;
  logic [31:0] noc_out_flit_o;
  logic        noc_out_last_o;
  logic        noc_out_valid_o;
  logic        noc_out_ready_i = 1'b1;
  logic [31:0] wbs_adr_i;
  logic [31:0] wbs_dat_i;
  logic        wbs_cyc_i;
  logic        wbs_stb_i;
  logic        wbs_we_i;
  logic [31:0] wbs_dat_o;
  logic        wbs_ack_o;
  logic        wbs_err_o;
  logic        irq_o;

  int          data_errors = 0;
  int          bus_errors = 0;
  int          cycle_count = 0;
  logic [31:0] rng_state = 32'd31;

  // Flits are stored as {last, flit}
  logic [32:0] out_q[$];
  logic [32:0] in_pkt[$];
  logic [32:0] exp_msg[$];
  logic [32:0] exp_reply[$];
  logic [31:0] rx_model[$];

  networkadapter_ct #(
    .TILE_ID (5'd3)
  ) dut0 (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] make_header(input logic [4:0] dest, input logic [2:0] cls,
                                              input logic [4:0] src);
    logic [31:0] h;
    h = 32'b0;
    h[31:27] = dest;
    h[26:24] = cls;
    h[23:19] = src;
    return h;
  endfunction

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  // Random back-pressure on the outgoing link
  always @(posedge clk) begin
    #1;
    rng_state = xorshift(rng_state);
    noc_out_ready_i = rng_state[0] | rng_state[5];
  end

  always @(negedge clk) begin
    if (!reset_i && noc_out_valid_o && noc_out_ready_i) begin
      out_q.push_back({noc_out_last_o, noc_out_flit_o});
    end
  end

  task automatic expect_equal(input logic [32:0] got, input logic [32:0] exp, input string what);
    assert (got === exp) else begin
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
      data_errors++;
    end
  endtask

  task automatic wb_transfer(input logic we, input logic [31:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic got_ack,
                             output logic got_err);
    int waits;
    @(posedge clk);
    #1;
    wbs_cyc_i = 1'b1;
    wbs_stb_i = 1'b1;
    wbs_we_i = we;
    wbs_adr_i = adr;
    wbs_dat_i = wdata;
    waits = 0;
    do begin
      @(negedge clk);
      waits++;
    end while (!wbs_ack_o && !wbs_err_o && waits < 8);
    got_ack = wbs_ack_o;
    got_err = wbs_err_o;
    rdata = wbs_dat_o;
    assert (got_ack || got_err) else begin
      $display("Wishbone access at %h was never answered", adr);
      bus_errors++;
    end
    assert (!(got_ack || got_err) || waits == 2) else begin
      $display("Wishbone access at %h was answered after %0d cycles instead of one",
               adr, waits - 1);
      bus_errors++;
    end
    @(posedge clk);
    #1;
    wbs_cyc_i = 1'b0;
    wbs_stb_i = 1'b0;
    wbs_we_i = 1'b0;
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        ack;
    logic        err;
    wb_transfer(1'b1, adr, data, rdata, ack, err);
    expect_equal(33'({ack, err}), 33'b10, "write response");
  endtask

  task automatic wb_read(input logic [31:0] adr, output logic [31:0] data);
    logic ack;
    logic err;
    wb_transfer(1'b0, adr, 32'b0, data, ack, err);
    expect_equal(33'({ack, err}), 33'b10, "read response");
  endtask

  // Drains in_pkt onto the incoming link
  task automatic noc_send();
    logic [32:0] f;
    while (in_pkt.size() != 0) begin
      f = in_pkt.pop_front();
      @(posedge clk);
      #1;
      noc_in_valid_i = 1'b1;
      noc_in_flit_i = f[31:0];
      noc_in_last_i = f[32];
      @(negedge clk);
      while (!noc_in_ready_o) @(negedge clk);
    end
    @(posedge clk);
    #1;
    noc_in_valid_i = 1'b0;
    noc_in_last_i = 1'b0;
  endtask

  // One output packet, matched by the class of its header
  task automatic check_packet();
    logic [32:0] f;
    logic [32:0] exp;
    logic [2:0]  cls;
    logic        first;
    logic        found;
    logic        done;
    first = 1'b1;
    done = 1'b0;
    cls = 3'd0;
    exp = 33'b0;
    while (!done) begin
      while (out_q.size() == 0) @(negedge clk);
      f = out_q.pop_front();
      if (first) cls = f[26:24];
      first = 1'b0;
      found = 1'b1;
      if (cls == 3'd3 && exp_reply.size() != 0) exp = exp_reply.pop_front();
      else if (cls == 3'd0 && exp_msg.size() != 0) exp = exp_msg.pop_front();
      else found = 1'b0;
      assert (found) else begin
        $display("FAIL %0t: unexpected flit %h on the output", $time, f);
        data_errors++;
      end
      if (found) expect_equal(f, exp, "output flit");
      done = f[32];
    end
  endtask

  initial begin
    logic [31:0] rdata;
    logic        ack;
    logic        err;
    logic [31:0] scratch_val;
    scratch_val = 32'ha5c3_1e7f;
    reset_i = 1'b1;
    noc_in_flit_i = 32'b0;
    noc_in_last_i = 1'b0;
    noc_in_valid_i = 1'b0;
    wbs_adr_i = 32'b0;
    wbs_dat_i = 32'b0;
    wbs_cyc_i = 1'b0;
    wbs_stb_i = 1'b0;
    wbs_we_i = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    reset_i = 1'b0;

    wb_read(32'h0, rdata);
    expect_equal(33'(rdata), 33'd3, "tile id");
    wb_write(32'h8, scratch_val);
    wb_read(32'h8, rdata);
    expect_equal(33'(rdata), 33'(scratch_val), "scratch readback");
    wb_transfer(1'b0, 32'h0030_0000, 32'b0, rdata, ack, err);
    expect_equal(33'({ack, err}), 33'b01, "unmapped response");

    // Remote query of the scratch register
    in_pkt.push_back({1'b0, make_header(5'd3, 3'd2, 5'd5)});
    in_pkt.push_back({1'b1, 32'h8});
    exp_reply.push_back({1'b0, make_header(5'd5, 3'd3, 5'd3)});
    exp_reply.push_back({1'b1, scratch_val});
    noc_send();
    check_packet();

    exp_msg.push_back({1'b0, make_header(5'd4, 3'd0, 5'd3)});
    exp_msg.push_back({1'b0, 32'h1234_5678});
    exp_msg.push_back({1'b1, 32'h0bad_f00d});
    wb_write(32'h0010_0000, make_header(5'd4, 3'd0, 5'd3));
    wb_write(32'h0010_0000, 32'h1234_5678);
    wb_write(32'h0010_0004, 32'h0bad_f00d);
    check_packet();

    // Inbound message into the receive FIFO
    in_pkt.push_back({1'b0, make_header(5'd3, 3'd0, 5'd6)});
    in_pkt.push_back({1'b0, 32'h0000_0011});
    in_pkt.push_back({1'b0, 32'h0000_0022});
    in_pkt.push_back({1'b1, 32'h0000_0033});
    foreach (in_pkt[k]) rx_model.push_back(in_pkt[k][31:0]);
    noc_send();
    for (int i = 0; i < 20 && !irq_o; i++) @(negedge clk);
    expect_equal(33'(irq_o), 33'd1, "irq after receive");
    for (int i = 0; i < 8; i++) begin
      wb_read(32'h0010_0004, rdata);
      if (rdata == 32'd4) break;
    end
    expect_equal(33'(rdata), 33'd4, "receive count");
    for (int i = 0; i < 4; i++) begin
      wb_read(32'h0010_0000, rdata);
      expect_equal(33'(rdata), 33'(rx_model.pop_front()), "received flit");
      expect_equal(33'(irq_o), 33'(i != 3), "irq after pop");
    end

    // Query and software packet compete for the output
    in_pkt.push_back({1'b0, make_header(5'd3, 3'd2, 5'd9)});
    in_pkt.push_back({1'b1, 32'h0});
    exp_reply.push_back({1'b0, make_header(5'd9, 3'd3, 5'd3)});
    exp_reply.push_back({1'b1, 32'd3});
    exp_msg.push_back({1'b0, make_header(5'd9, 3'd0, 5'd3)});
    exp_msg.push_back({1'b0, 32'h5555_aaaa});
    exp_msg.push_back({1'b1, 32'h0f0f_f0f0});
    fork
      noc_send();
      begin
        wb_write(32'h0010_0000, make_header(5'd9, 3'd0, 5'd3));
        wb_write(32'h0010_0000, 32'h5555_aaaa);
        wb_write(32'h0010_0004, 32'h0f0f_f0f0);
      end
    join
    check_packet();
    check_packet();
    expect_equal(33'(exp_reply.size() + exp_msg.size()), 33'd0, "flits still expected");

    $display("Errors: %0d data, %0d bus", data_errors, bus_errors);
    if (data_errors == 0 && bus_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- wb_decode.sv
`timescale 1ns/100ps

module wb_decode (
  input  logic        clk,
  input  logic        reset_i,
  input  logic [31:0] wbs_adr_i,
  input  logic [31:0] wbs_dat_i,
  input  logic        wbs_cyc_i,
  input  logic        wbs_stb_i,
  input  logic        wbs_we_i,
  output logic [31:0] wbs_dat_o,
  output logic        wbs_ack_o,
  output logic        wbs_err_o,
  wb_slave_if.master  conf_bus,
  wb_slave_if.master  mp_bus
);
  import na_pkg::*;

  logic [3:0] adr_range;
  logic       access;
  logic       unmapped;
  logic       err_q;

  assign adr_range = wbs_adr_i[23:20];
  assign access = wbs_cyc_i && wbs_stb_i;
  assign unmapped = (adr_range != sl_conf) && (adr_range != sl_mp);

  assign conf_bus.adr = wbs_adr_i[wb_adr_width-1:0];
  assign conf_bus.dat_w = wbs_dat_i;
  assign conf_bus.we = wbs_we_i;
  assign conf_bus.req = access && (adr_range == sl_conf);
  assign mp_bus.adr = wbs_adr_i[wb_adr_width-1:0];
  assign mp_bus.dat_w = wbs_dat_i;
  assign mp_bus.we = wbs_we_i;
  assign mp_bus.req = access && (adr_range == sl_mp);

  always_comb begin
    case (adr_range)
      sl_conf: begin
        wbs_dat_o = conf_bus.dat_r;
        wbs_ack_o = conf_bus.ack;
      end
      sl_mp: begin
        wbs_dat_o = mp_bus.dat_r;
        wbs_ack_o = mp_bus.ack;
      end
      default: begin
        wbs_dat_o = '0;
        wbs_ack_o = 1'b0;
      end
    endcase
  end

  // One-cycle err for unmapped ranges
  always_ff @(posedge clk) begin
    if (reset_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= access && unmapped && !err_q;
    end
  end

  assign wbs_err_o = err_q;

endmodule

//--- wb_slave_if.sv
`timescale 1ns/100ps

interface wb_slave_if;
  import na_pkg::*;

  logic [wb_adr_width-1:0] adr;
  logic [31:0]             dat_w;
  logic                    we;
  logic                    req;
  logic [31:0]             dat_r;
  logic                    ack;

  modport master (
    output adr,
    output dat_w,
    output we,
    output req,
    input  dat_r,
    input  ack
  );

  modport slave (
    input  adr,
    input  dat_w,
    input  we,
    input  req,
    output dat_r,
    output ack
  );

endinterface
